//--- common/map_params.svh
`ifndef MAP_PARAMS_SVH
`define MAP_PARAMS_SVH

// base of the four byte register window.
`define MAP_REG_BASE 16'h4100

// identifier returned on the save-state id address.
`define MAP_NUM 8'd27

// save-state address that holds the mapper id.
`define SS_ID_ADDR 8'd127

// saved bytes: addresses 0 to 4 plus the id.
`define SS_SLOTS 6

// state buffer address width.
`define SS_BUF_AW 3

`endif

//--- common/map_pkg.sv
// shared types for the mapper 132 subsystem.
package map_pkg;

	// cpu bus as seen by the cartridge.
	// rw is high for a read, ce is low for the rom area at $8000 and up.
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dat;
		logic        rw;
		logic        ce;
	} cpu_bus_t;

	// ppu bus, strobes active low.
	typedef struct packed {
		logic [13:0] addr;
		logic        oe;
		logic        we;
	} ppu_bus_t;

	// cartridge configuration from the loader.
	typedef struct packed {
		logic chr_ram;
		logic mir_v;
	} sys_cfg_t;

	// save-state strobes into the mapper.
	// write data rides on the cpu data bus.
	typedef struct packed {
		logic       act;
		logic       we;
		logic [7:0] addr;
	} ss_ctrl_t;

	// everything the mapper drives out to the cartridge pins and the engine.
	typedef struct packed {
		logic [15:0] prg_addr;
		logic        prg_oe;
		logic        rom_ce;
		logic [14:0] chr_addr;
		logic        chr_ce;
		logic        chr_we;
		logic        chr_oe;
		logic        ciram_a10;
		logic        ciram_ce;
		logic        ram_ce;
		logic        ram_we;
		logic        map_cpu_oe;
		logic [7:0]  map_cpu_dout;
		logic [7:0]  ss_rdat;
	} map_out_t;

endpackage

//--- map_132/map_132.sv
`timescale 1ns/100ps
`include "map_params.svh"

// mapper 132: small register file with a protection readback,
// one prg bank bit and two chr bank bits latched from register 2.
module map_132 (
	input  logic               m2,
	input  logic               map_rst,
	input  map_pkg::cpu_bus_t  cpu,
	input  map_pkg::ppu_bus_t  ppu,
	input  map_pkg::sys_cfg_t  cfg,
	input  map_pkg::ss_ctrl_t  ss,
	output map_pkg::map_out_t  pins
);

	logic [3:0][7:0] regs;
	logic            prg_bank;
	logic [1:0]      chr_bank;
	logic            reg_hit;
	logic            ciram_ce;
	logic [7:0]      ss_rdat;

	// $4100-$4103, mirrored only on the low two address bits.
	assign reg_hit = {cpu.addr[15:2], 2'b00} == `MAP_REG_BASE;

	// nametable ram sits in $2000-$3fff of ppu space.
	assign ciram_ce = !ppu.addr[13];

	// registers follow the cpu on the falling edge of m2.
	// a save-state transfer takes over all writes and masks reset.
	always_ff @(negedge m2) begin
		if (ss.act) begin
			if (ss.we && ss.addr[7:2] == 6'd0) begin
				regs[ss.addr[1:0]] <= cpu.dat;
			end
			if (ss.we && ss.addr == 8'd4) begin
				{prg_bank, chr_bank} <= cpu.dat[2:0];
			end
		end else if (map_rst) begin
			regs     <= '0;
			prg_bank <= 1'b0;
			chr_bank <= 2'b00;
		end else begin
			if (!cpu.rw && reg_hit) begin
				regs[cpu.addr[1:0]] <= cpu.dat;
			end
			// any write to rom space latches the banks from register 2.
			if (!cpu.rw && !cpu.ce) begin
				prg_bank <= regs[2][2];
				chr_bank <= regs[2][1:0];
			end
		end
	end

	// save-state readback.
	always_comb begin
		if (ss.addr[7:2] == 6'd0) begin
			ss_rdat = regs[ss.addr[1:0]];
		end else if (ss.addr == 8'd4) begin
			ss_rdat = {5'd0, prg_bank, chr_bank};
		end else if (ss.addr == `SS_ID_ADDR) begin
			ss_rdat = `MAP_NUM;
		end else begin
			ss_rdat = 8'hff;
		end
	end

	// pin decode, all combinational.
	always_comb begin
		// 32k prg window, one bank bit on top.
		pins.prg_addr  = {prg_bank, cpu.addr[14:0]};
		pins.prg_oe    = cpu.rw;
		pins.rom_ce    = !cpu.ce;

		// 8k chr window, two bank bits on top.
		pins.chr_addr  = {chr_bank, ppu.addr[12:0]};
		pins.chr_ce    = ciram_ce;
		pins.chr_oe    = !ppu.oe;
		// without chr ram there is nothing to write.
		pins.chr_we    = cfg.chr_ram ? (!ppu.we && ciram_ce) : 1'b0;

		// a10 for vertical, a11 for horizontal mirroring.
		pins.ciram_a10 = cfg.mir_v ? ppu.addr[10] : ppu.addr[11];
		pins.ciram_ce  = ciram_ce;

		// no prg ram on this board.
		pins.ram_ce    = 1'b0;
		pins.ram_we    = !cpu.rw;

		// protection read: fixed 01 on top, xor of regs 1 and 2 below.
		pins.map_cpu_oe   = reg_hit && cpu.rw && m2;
		pins.map_cpu_dout = {2'b01, regs[1][5:0] ^ regs[2][5:0]};

		pins.ss_rdat = ss_rdat;
	end

endmodule

//--- nes_map132.f
+incdir+common
common/map_pkg.sv
map_132/map_132.sv
rtl/ss_engine.sv
rtl/map_sub_top.sv
verification/map_sub_tb.sv

//--- rtl/map_sub_top.sv
`timescale 1ns/100ps
`include "map_params.svh"

// mapper 132 with its save-state engine.
module map_sub_top (
	input  logic                  m2,
	input  logic                  map_rst,
	input  map_pkg::cpu_bus_t     cpu,
	input  map_pkg::ppu_bus_t     ppu,
	input  map_pkg::sys_cfg_t     cfg,
	input  logic                  ss_start,
	input  logic                  ss_load,
	input  logic                  buf_we,
	input  logic [`SS_BUF_AW-1:0] buf_addr,
	input  logic [7:0]            buf_wdat,
	output map_pkg::map_out_t     pins,
	output logic                  ss_busy,
	output logic                  ss_done,
	output logic                  ss_bad,
	output logic [7:0]            buf_rdat
);

	import map_pkg::*;

	ss_ctrl_t   ss_ctrl;
	cpu_bus_t   map_cpu;
	logic [7:0] ss_wdat;

	// restore data goes in on the cpu data lines, the mapper
	// ignores the rest of the bus while the engine is active.
	always_comb begin
		map_cpu = cpu;
		if (ss_ctrl.act) begin
			map_cpu.dat = ss_wdat;
		end
	end

	map_132 u_map (
		.m2      (m2),
		.map_rst (map_rst),
		.cpu     (map_cpu),
		.ppu     (ppu),
		.cfg     (cfg),
		.ss      (ss_ctrl),
		.pins    (pins)
	);

	ss_engine u_ss (
		.m2       (m2),
		.map_rst  (map_rst),
		.ss_start (ss_start),
		.ss_load  (ss_load),
		.buf_we   (buf_we),
		.buf_addr (buf_addr),
		.buf_wdat (buf_wdat),
		.ss_rdat  (pins.ss_rdat),
		.ss       (ss_ctrl),
		.ss_wdat  (ss_wdat),
		.ss_busy  (ss_busy),
		.ss_done  (ss_done),
		.ss_bad   (ss_bad),
		.buf_rdat (buf_rdat)
	);

endmodule

//--- rtl/ss_engine.sv
`timescale 1ns/100ps
`include "map_params.svh"

// save-state sequencer.
// save walks all slots into the buffer, restore checks the id slot
// first and only then writes the register slots back.
module ss_engine (
	input  logic                  m2,
	input  logic                  map_rst,
	input  logic                  ss_start,
	input  logic                  ss_load,
	input  logic                  buf_we,
	input  logic [`SS_BUF_AW-1:0] buf_addr,
	input  logic [7:0]            buf_wdat,
	input  logic [7:0]            ss_rdat,
	output map_pkg::ss_ctrl_t     ss,
	output logic [7:0]            ss_wdat,
	output logic                  ss_busy,
	output logic                  ss_done,
	output logic                  ss_bad,
	output logic [7:0]            buf_rdat
);

	localparam int LAST_IDX = `SS_SLOTS - 1;
	localparam int LOAD_IDX = `SS_SLOTS - 2;
	localparam logic [`SS_BUF_AW-1:0] LAST_SLOT = LAST_IDX[`SS_BUF_AW-1:0];
	localparam logic [`SS_BUF_AW-1:0] LAST_LOAD = LOAD_IDX[`SS_BUF_AW-1:0];

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SAVE,
		ST_CHECK,
		ST_LOAD,
		ST_DONE
	} state_t;

	state_t                 state;
	logic [`SS_BUF_AW-1:0]  slot;
	logic [7:0]             ss_mem [`SS_SLOTS];

	always_ff @(negedge m2) begin
		if (map_rst) begin
			state  <= ST_IDLE;
			slot   <= '0;
			ss_bad <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (ss_start) begin
						ss_bad <= 1'b0;
						if (ss_load) begin
							// the id slot is checked before anything is written.
							state <= ST_CHECK;
							slot  <= LAST_SLOT;
						end else begin
							state <= ST_SAVE;
							slot  <= '0;
						end
					end
				end
				ST_SAVE: begin
					if (slot == LAST_SLOT) begin
						state <= ST_DONE;
					end else begin
						slot <= slot + 1'b1;
					end
				end
				ST_CHECK: begin
					if (ss_mem[slot] == ss_rdat) begin
						state <= ST_LOAD;
						slot  <= '0;
					end else begin
						ss_bad <= 1'b1;
						state  <= ST_DONE;
					end
				end
				ST_LOAD: begin
					if (slot == LAST_LOAD) begin
						state <= ST_DONE;
					end else begin
						slot <= slot + 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// buffer: the engine fills it on save, the host only while idle.
	always_ff @(negedge m2) begin
		if (state == ST_SAVE) begin
			ss_mem[slot] <= ss_rdat;
		end else if (buf_we && !ss_busy && buf_addr < `SS_SLOTS) begin
			ss_mem[buf_addr] <= buf_wdat;
		end
	end

	assign ss_busy  = state != ST_IDLE;
	assign ss_done  = state == ST_DONE;
	assign ss_wdat  = ss_mem[slot];
	assign buf_rdat = (buf_addr < `SS_SLOTS) ? ss_mem[buf_addr] : 8'hff;

	// last slot maps to the id address, the rest map straight through.
	always_comb begin
		ss.act  = state == ST_SAVE || state == ST_CHECK || state == ST_LOAD;
		ss.we   = state == ST_LOAD;
		ss.addr = (slot == LAST_SLOT) ? `SS_ID_ADDR : {{(8 - `SS_BUF_AW){1'b0}}, slot};
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the mapper 132 testbench with verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/100ps -j 0 \
	--top-module map_sub_tb -f nes_map132.f

./obj_dir/Vmap_sub_tb > sim.log 2>&1
cat sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"

//--- verification/map_stimulus.mem
// columns: op addr data expect, hex. op 0 reset, 1 cpu write, 2 cpu read (data = oe),
// 3 bank (data = ppu addr), 4 ppu (data = mode), 5/8 buffer write/read, 6/7 save/load.
2 4100 1 40
3 8000 0000 0
1 4100 a5 0
1 4101 3c 0
1 4102 16 0
1 4103 c3 0
2 4100 1 6a
2 4103 1 6a
2 4104 0 0
2 6000 0 0
3 8123 0456 0
1 8000 00 0
3 c321 1abc 6
1 4102 01 0
3 8000 0000 6
2 4101 1 7d
4 2400 0 0
4 2400 1 1
4 2800 0 1
4 2800 1 0
4 0c00 1 3
4 0400 6 6
4 0400 4 2
4 2000 6 0
6 0 7 0
8 0 0 a5
8 1 0 3c
8 2 0 01
8 3 0 c3
8 4 0 06
8 5 0 1b
0 0 0 0
2 4100 1 40
3 8000 0000 0
7 0 7 0
2 4100 1 7d
3 8000 0000 6
5 1 ff 0
5 5 2a 0
8 5 0 2a
7 0 2 1
2 4100 1 7d
3 8000 0000 6
5 5 1b 0
7 0 7 0
2 4102 1 7e
f 0 0 0

//--- verification/map_sub_tb.sv
`timescale 1ns/100ps
`include "map_params.svh"

module map_sub_tb;

	import map_pkg::*;

	localparam int MAX_VEC        = 64;
	localparam int CYCLES_PER_VEC = 10;
	localparam int DONE_WAIT      = 20;

	localparam logic [15:0] OP_RESET  = 16'h0000;
	localparam logic [15:0] OP_WRITE  = 16'h0001;
	localparam logic [15:0] OP_READ   = 16'h0002;
	localparam logic [15:0] OP_BANK   = 16'h0003;
	localparam logic [15:0] OP_PPU    = 16'h0004;
	localparam logic [15:0] OP_BUF_WR = 16'h0005;
	localparam logic [15:0] OP_SAVE   = 16'h0006;
	localparam logic [15:0] OP_LOAD   = 16'h0007;
	localparam logic [15:0] OP_BUF_RD = 16'h0008;
	localparam logic [15:0] OP_END    = 16'h000f;

	logic                  m2;
	logic                  map_rst;
	cpu_bus_t              cpu;
	ppu_bus_t              ppu;
	sys_cfg_t              cfg;
	logic                  ss_start;
	logic                  ss_load;
	logic                  buf_we;
	logic [`SS_BUF_AW-1:0] buf_addr;
	logic [7:0]            buf_wdat;
	map_out_t              pins;
	logic                  ss_busy;
	logic                  ss_done;
	logic                  ss_bad;
	logic [7:0]            buf_rdat;

	// four words per vector: op, addr, data, expect.
	logic [15:0] vec_mem [0:4*MAX_VEC-1];
	int          n_vec;
	int          cycle_limit = 0;
	int          cycle_count = 0;
	int          value_errors = 0;
	int          other_errors = 0;

	map_sub_top dut (
		.m2       (m2),
		.map_rst  (map_rst),
		.cpu      (cpu),
		.ppu      (ppu),
		.cfg      (cfg),
		.ss_start (ss_start),
		.ss_load  (ss_load),
		.buf_we   (buf_we),
		.buf_addr (buf_addr),
		.buf_wdat (buf_wdat),
		.pins     (pins),
		.ss_busy  (ss_busy),
		.ss_done  (ss_done),
		.ss_bad   (ss_bad),
		.buf_rdat (buf_rdat)
	);

	initial begin
		m2 = 1'b0;
		forever #20 m2 = ~m2;
	end

	// bus at rest: cpu reading outside rom, ppu strobes off, host port quiet.
	task automatic drive_idle();
		cpu.addr = 16'h0000;
		cpu.dat  = 8'h00;
		cpu.rw   = 1'b1;
		cpu.ce   = 1'b1;
		ppu.addr = 14'h0000;
		ppu.oe   = 1'b1;
		ppu.we   = 1'b1;
		ss_start = 1'b0;
		ss_load  = 1'b0;
		buf_we   = 1'b0;
		buf_addr = '0;
		buf_wdat = 8'h00;
	endtask

	// inputs change 5 ns after the rising edge.
	task automatic next_drive();
		@(posedge m2);
		#5;
	endtask

	task automatic check_value(input string what, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got === exp) else begin
			value_errors++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// a cpu read selects the rom only from $8000 up and never touches prg ram.
	task automatic cpu_select_check(input logic [15:0] addr);
		check_value("rom_ce", 16'(pins.rom_ce), 16'(addr[15]));
		check_value("prg_oe", 16'(pins.prg_oe), 16'h0001);
		check_value("ram_ce", 16'(pins.ram_ce), 16'h0000);
		check_value("ram_we", 16'(pins.ram_we), 16'h0000);
	endtask

	task automatic apply_reset();
		next_drive();
		drive_idle();
		map_rst = 1'b1;
		repeat (5) @(posedge m2);
		#5;
		map_rst = 1'b0;
		#10;
		check_value("ss_busy after reset", 16'(ss_busy), 16'h0000);
		check_value("ss_done after reset", 16'(ss_done), 16'h0000);
		check_value("ss_bad after reset", 16'(ss_bad), 16'h0000);
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [15:0] data);
		next_drive();
		drive_idle();
		cpu.addr = addr;
		cpu.dat  = data[7:0];
		cpu.rw   = 1'b0;
		cpu.ce   = !addr[15];
	endtask

	// checked while m2 is still high, since the readback only drives then.
	task automatic cpu_read(input logic [15:0] addr, input logic [15:0] oe_exp,
		input logic [15:0] exp);
		next_drive();
		drive_idle();
		cpu.addr = addr;
		cpu.ce   = !addr[15];
		#10;
		check_value("map_cpu_oe", 16'(pins.map_cpu_oe), oe_exp);
		if (oe_exp[0]) begin
			check_value("map_cpu_dout", 16'(pins.map_cpu_dout), exp);
		end
		cpu_select_check(addr);
	endtask

	// bank bits on top, bus address bits below.
	task automatic bank_check(input logic [15:0] addr, input logic [15:0] ppu_a,
		input logic [15:0] exp);
		next_drive();
		drive_idle();
		cpu.addr = addr;
		cpu.ce   = !addr[15];
		ppu.addr = ppu_a[13:0];
		#10;
		check_value("prg_addr", pins.prg_addr, {exp[2], addr[14:0]});
		check_value("chr_addr", 16'(pins.chr_addr), 16'({exp[1:0], ppu_a[12:0]}));
		cpu_select_check(addr);
	endtask

	// mode: bit 0 mir_v, bit 1 chr_ram, bit 2 ppu write.
	task automatic ppu_check(input logic [15:0] addr, input logic [15:0] mode,
		input logic [15:0] exp);
		next_drive();
		drive_idle();
		cfg.mir_v   = mode[0];
		cfg.chr_ram = mode[1];
		ppu.addr    = addr[13:0];
		ppu.we      = !mode[2];
		ppu.oe      = mode[2];
		#10;
		check_value("chr_we/ciram_ce/ciram_a10",
			16'({pins.chr_we, pins.ciram_ce, pins.ciram_a10}), exp);
		// chr is selected below $2000 and read whenever the ppu is not writing.
		check_value("chr_ce", 16'(pins.chr_ce), 16'(!addr[13]));
		check_value("chr_oe", 16'(pins.chr_oe), 16'(!mode[2]));
	endtask

	task automatic buffer_write(input logic [15:0] addr, input logic [15:0] data);
		next_drive();
		drive_idle();
		buf_we   = 1'b1;
		buf_addr = addr[`SS_BUF_AW-1:0];
		buf_wdat = data[7:0];
	endtask

	task automatic buffer_check(input logic [15:0] addr, input logic [15:0] exp);
		next_drive();
		drive_idle();
		buf_addr = addr[`SS_BUF_AW-1:0];
		#10;
		check_value("buf_rdat", 16'(buf_rdat), exp);
	endtask

	// one-cycle start, then count cycles until ss_done.
	task automatic state_transfer(input logic load, input logic [15:0] cycles_exp,
		input logic [15:0] bad_exp);
		int waited;
		next_drive();
		drive_idle();
		ss_start = 1'b1;
		ss_load  = load;
		#10;
		waited = 0;
		while (!ss_done && waited < DONE_WAIT) begin
			next_drive();
			ss_start = 1'b0;
			ss_load  = 1'b0;
			#10;
			waited++;
			assert (ss_busy) else begin
				other_errors++;
				$display("engine was idle before ss_done at %0t", $time);
			end
		end
		assert (ss_done) else begin
			other_errors++;
			$display("engine gave no ss_done within %0d cycles", DONE_WAIT);
		end
		check_value("transfer cycles", 16'(waited), cycles_exp);
		check_value("ss_bad", 16'(ss_bad), bad_exp);
	endtask

	task automatic run_vector(input logic [15:0] op, input logic [15:0] addr,
		input logic [15:0] data, input logic [15:0] exp);
		case (op)
			OP_RESET:  apply_reset();
			OP_WRITE:  cpu_write(addr, data);
			OP_READ:   cpu_read(addr, data, exp);
			OP_BANK:   bank_check(addr, data, exp);
			OP_PPU:    ppu_check(addr, data, exp);
			OP_BUF_WR: buffer_write(addr, data);
			OP_SAVE:   state_transfer(1'b0, data, exp);
			OP_LOAD:   state_transfer(1'b1, data, exp);
			OP_BUF_RD: buffer_check(addr, exp);
			default: begin
				other_errors++;
				$display("unknown operation code %h in the vector file", op);
			end
		endcase
	endtask

	// watchdog over the whole run.
	initial begin
		while (cycle_limit == 0 || cycle_count < cycle_limit) begin
			@(posedge m2);
			cycle_count++;
		end
		$display("timeout: run went past %0d cycles", cycle_limit);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		int idx;
		for (idx = 0; idx < 4 * MAX_VEC; idx++) begin
			vec_mem[idx] = OP_END;
		end
		$readmemh("verification/map_stimulus.mem", vec_mem);
		n_vec = 0;
		while (n_vec < MAX_VEC && vec_mem[4 * n_vec] != OP_END) begin
			n_vec++;
		end
		cycle_limit = n_vec * CYCLES_PER_VEC;
		drive_idle();
		cfg     = '0;
		map_rst = 1'b1;
		assert (n_vec > 0) else begin
			other_errors++;
			$display("the vector file holds no vectors");
		end
		apply_reset();
		for (idx = 0; idx < n_vec; idx++) begin
			run_vector(vec_mem[4 * idx], vec_mem[4 * idx + 1], vec_mem[4 * idx + 2],
				vec_mem[4 * idx + 3]);
		end
		next_drive();
		drive_idle();
		$display("errors: %0d mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
